// File: include/spi_regmap.svh
`ifndef SPI_REGMAP_SVH
`define SPI_REGMAP_SVH

//##########################################################################
// control register addresses
//##########################################################################

// config byte
`define SPI_CONFIG      6'd0
// status byte, bit 0 is core data waiting
`define SPI_STATUS      6'd1

//##########################################################################
// config bits
//##########################################################################

// user bytes valid for the core
`define CFG_USER_VALID  0
// blocks spi writes outside config
`define CFG_DISABLE     1

`endif

// File: verilog/spi_slave_pkg.sv
package spi_slave_pkg;

   //##########################################################################
   // data widths
   //##########################################################################

   // one register byte as seen over spi
   typedef logic [7:0]  byte_t;
   // 64 byte register map
   typedef logic [5:0]  reg_addr_t;
   // word pushed by the core agent
   typedef logic [63:0] core_data_t;

   //##########################################################################
   // register map layout
   //##########################################################################

   // user space, addresses 16..63
   localparam int NUM_USER_REGS = 48;
   localparam int USER_BASE     = 16;

   // core data window, lsb first
   localparam int CORE_BASE     = 8;
   // reading this byte releases the word
   localparam int CORE_LAST     = 15;

   //##########################################################################
   // core queue
   //##########################################################################

   // entries, also the agent's credits after reset
   localparam int QUEUE_DEPTH   = 2;
   localparam int QUEUE_PTR_W   = $clog2(QUEUE_DEPTH);
   localparam int QUEUE_CNT_W   = $clog2(QUEUE_DEPTH + 1);

   // serial engine states
   typedef enum logic [1:0] {
      IDLE,
      CMD,
      DATA
   } spi_state_t;

endpackage

// File: verilog/spi_slave_io.sv
`include "spi_regmap.svh"

module spi_slave_io (
   input  logic                    clk,
   input  logic                    nreset,
   input  logic                    sclk,
   input  logic                    ss_n,
   input  logic                    mosi,
   output logic                    miso,
   input  logic                    spi_disable,
   output logic                    rd_en,
   output spi_slave_pkg::reg_addr_t rd_addr,
   input  spi_slave_pkg::byte_t     rd_data,
   output logic                    wr_en,
   output spi_slave_pkg::reg_addr_t wr_addr,
   output spi_slave_pkg::byte_t     wr_data
);
   import spi_slave_pkg::*;

   // [1:0] sync stages, [2] previous value for edge detect
   logic [2:0]  sclk_pipe;
   logic [1:0]  ss_pipe;
   logic [1:0]  mosi_pipe;
   logic        ss_s;
   logic        mosi_s;
   logic        sclk_rise;
   logic        sclk_fall;

   spi_state_t  state;
   logic [2:0]  bit_cnt;
   logic        is_read;
   reg_addr_t   addr;
   logic        miso_r;
   logic        byte_last;
   logic        wr_allow;
   byte_t       rx_shift;
   byte_t       rx_byte;
   byte_t       tx_shift;

   //##########################################################################
   // pin synchronizers
   //##########################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         sclk_pipe <= '0;
         // slave deselected out of reset
         ss_pipe   <= '1;
         mosi_pipe <= '0;
      end
      else
      begin
         sclk_pipe <= {sclk_pipe[1:0], sclk};
         ss_pipe   <= {ss_pipe[0], ss_n};
         mosi_pipe <= {mosi_pipe[0], mosi};
      end
   end

   assign ss_s      = ss_pipe[1];
   assign mosi_s    = mosi_pipe[1];
   // mode 0, sample on rise, shift out on fall
   assign sclk_rise = sclk_pipe[1] & ~sclk_pipe[2];
   assign sclk_fall = ~sclk_pipe[1] & sclk_pipe[2];

   // byte being completed on this rising edge
   assign rx_byte   = {rx_shift[6:0], mosi_s};
   assign byte_last = sclk_rise & (bit_cnt == 3'd7);

   // disable only lets config through
   assign wr_allow  = ~spi_disable | (addr == `SPI_CONFIG);

   //##########################################################################
   // frame state machine
   //##########################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state   <= IDLE;
         bit_cnt <= '0;
         is_read <= 1'b0;
         addr    <= '0;
         rd_en   <= 1'b0;
         wr_en   <= 1'b0;
         miso_r  <= 1'b0;
      end
      else
      begin
         // strobes are single cycle
         rd_en <= 1'b0;
         wr_en <= 1'b0;
         case (state)
            IDLE:
            begin
               bit_cnt <= '0;
               miso_r  <= 1'b0;
               if (!ss_s)
                  state <= CMD;
            end
            CMD:
            begin
               if (ss_s)
                  state <= IDLE;
               else if (sclk_rise)
               begin
                  bit_cnt <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7)
                  begin
                     // bit 7 read, bit 6 ignored, bits 5:0 start address
                     is_read <= rx_byte[7];
                     addr    <= rx_byte[5:0];
                     // read fetches the first byte right away
                     rd_en   <= rx_byte[7];
                     state   <= DATA;
                  end
               end
            end
            DATA:
            begin
               if (ss_s)
                  state <= IDLE;
               else
               begin
                  // fetch cycle done, step to next address
                  if (rd_en)
                     addr <= addr + 1'b1;
                  if (sclk_rise)
                  begin
                     bit_cnt <= bit_cnt + 3'd1;
                     if (bit_cnt == 3'd7)
                     begin
                        if (is_read)
                           rd_en <= 1'b1;
                        else
                        begin
                           wr_en <= wr_allow;
                           addr  <= addr + 1'b1;
                        end
                     end
                  end
                  if (sclk_fall && is_read)
                     miso_r <= tx_shift[7];
               end
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   //##########################################################################
   // shift registers and write payload
   //##########################################################################

   always_ff @(posedge clk)
   begin
      if (sclk_rise)
         rx_shift <= rx_byte;
      // msb first out
      if (rd_en)
         tx_shift <= rd_data;
      else if (sclk_fall)
         tx_shift <= {tx_shift[6:0], 1'b0};
      if (byte_last)
      begin
         wr_addr <= addr;
         wr_data <= rx_byte;
      end
   end

   // read address follows the frame pointer
   assign rd_addr = addr;
   // quiet line whenever deselected
   assign miso    = miso_r & ~ss_n;

   // a read fetch and a write strobe never share a cycle
   assert property (@(posedge clk) disable iff (!nreset) !(wr_en && rd_en))
      else $error("spi_slave_io: rd_en and wr_en together");

   // deselect always ends the frame
   assert property (@(posedge clk) disable iff (!nreset) ss_s |=> (state == IDLE))
      else $error("spi_slave_io: frame not closed after ss_n high");

endmodule

// File: verilog/spi_slave_regs.sv
`include "spi_regmap.svh"

module spi_slave_regs (
   input  logic                                       clk,
   input  logic                                       nreset,
   input  logic                                       rd_en,
   input  spi_slave_pkg::reg_addr_t                   rd_addr,
   output spi_slave_pkg::byte_t                       rd_data,
   input  logic                                       wr_en,
   input  spi_slave_pkg::reg_addr_t                   wr_addr,
   input  spi_slave_pkg::byte_t                       wr_data,
   output logic                                       spi_disable,
   input  logic                                       load_en,
   input  spi_slave_pkg::core_data_t                  load_data,
   output logic                                       core_pending,
   output logic                                       user_valid,
   output logic [spi_slave_pkg::NUM_USER_REGS*8-1:0]  user_regs
);
   import spi_slave_pkg::*;

   byte_t       cfg_reg;
   core_data_t  core_word;
   byte_t       user_mem [NUM_USER_REGS];

   logic        cfg_wr;
   logic        user_wr;
   logic        core_rd_last;
   reg_addr_t   user_wr_idx;
   reg_addr_t   user_rd_idx;
   reg_addr_t   core_off;

   //##########################################################################
   // write decode
   //##########################################################################

   assign cfg_wr      = wr_en & (wr_addr == `SPI_CONFIG);
   // status, reserved and core window drop writes
   assign user_wr     = wr_en & (wr_addr >= reg_addr_t'(USER_BASE));
   assign user_wr_idx = wr_addr - reg_addr_t'(USER_BASE);

   // side effect of fetching the top core byte
   assign core_rd_last = rd_en & (rd_addr == reg_addr_t'(CORE_LAST));

   //##########################################################################
   // config
   //##########################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         cfg_reg <= '0;
      else if (cfg_wr)
         cfg_reg <= wr_data;
   end

   assign user_valid  = cfg_reg[`CFG_USER_VALID];
   assign spi_disable = cfg_reg[`CFG_DISABLE];

   //##########################################################################
   // status and core data
   //##########################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         core_pending <= 1'b0;
         core_word    <= '0;
      end
      else if (load_en)
      begin
         // new word from the queue
         core_pending <= 1'b1;
         core_word    <= load_data;
      end
      else if (core_rd_last)
         core_pending <= 1'b0;
   end

   //##########################################################################
   // user bytes
   //##########################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < NUM_USER_REGS; i++)
            user_mem[i] <= '0;
      end
      else if (user_wr)
         user_mem[user_wr_idx] <= wr_data;
   end

   // flat export, byte 0 is address 16
   always_comb
   begin
      for (int i = 0; i < NUM_USER_REGS; i++)
         user_regs[i*8 +: 8] = user_mem[i];
   end

   //##########################################################################
   // read mux
   //##########################################################################

   assign core_off    = rd_addr - reg_addr_t'(CORE_BASE);
   assign user_rd_idx = rd_addr - reg_addr_t'(USER_BASE);

   always_comb
   begin
      // reserved space reads zero
      rd_data = '0;
      if (rd_addr == `SPI_CONFIG)
         rd_data = cfg_reg;
      else if (rd_addr == `SPI_STATUS)
         rd_data = {7'b0, core_pending};
      else if (rd_addr >= reg_addr_t'(CORE_BASE) && rd_addr <= reg_addr_t'(CORE_LAST))
         rd_data = core_word[{core_off[2:0], 3'b000} +: 8];
      else if (rd_addr >= reg_addr_t'(USER_BASE))
         rd_data = user_mem[user_rd_idx];
   end

   // queue must wait until the previous word was read out
   assert property (@(posedge clk) disable iff (!nreset) load_en |-> !core_pending)
      else $error("spi_slave_regs: core load while word still pending");

endmodule

// File: verilog/core_packet_queue.sv
module core_packet_queue (
   input  logic                       clk,
   input  logic                       nreset,
   input  logic                       core_access,
   input  spi_slave_pkg::core_data_t  core_data,
   output logic                       core_credit,
   input  logic                       core_pending,
   output logic                       load_en,
   output spi_slave_pkg::core_data_t  load_data
);
   import spi_slave_pkg::*;

   core_data_t              fifo_mem [QUEUE_DEPTH];
   logic [QUEUE_PTR_W-1:0]  wr_ptr;
   logic [QUEUE_PTR_W-1:0]  rd_ptr;
   logic [QUEUE_CNT_W-1:0]  count;
   logic                    push;
   logic                    pop;

   //##########################################################################
   // push and pop
   //##########################################################################

   assign push = core_access;
   // hand over only once the register file is free
   assign pop  = (count != '0) & ~core_pending;

   assign load_en     = pop;
   assign load_data   = fifo_mem[rd_ptr];
   // every pop frees a slot for the agent
   assign core_credit = pop;

   // storage
   always_ff @(posedge clk)
   begin
      if (push)
         fifo_mem[wr_ptr] <= core_data;
   end

   // pointers and fill level
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
         begin
            if (wr_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1))
               wr_ptr <= '0;
            else
               wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop)
         begin
            if (rd_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1))
               rd_ptr <= '0;
            else
               rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // agent honours its credits
   assert property (@(posedge clk) disable iff (!nreset)
                    core_access |-> (count < QUEUE_CNT_W'(QUEUE_DEPTH)))
      else $error("core_packet_queue: push while full");

endmodule

// File: verilog/spi_slave.sv
module spi_slave (
   input  logic                                       clk,
   input  logic                                       nreset,
   // spi pins
   input  logic                                       sclk,
   input  logic                                       ss_n,
   input  logic                                       mosi,
   output logic                                       miso,
   // core agent
   input  logic                                       core_access,
   input  spi_slave_pkg::core_data_t                  core_data,
   output logic                                       core_credit,
   // user space export
   output logic                                       user_valid,
   output logic [spi_slave_pkg::NUM_USER_REGS*8-1:0]  user_regs
);
   import spi_slave_pkg::*;

   // engine to register file
   logic        rd_en;
   reg_addr_t   rd_addr;
   byte_t       rd_data;
   logic        wr_en;
   reg_addr_t   wr_addr;
   byte_t       wr_data;
   logic        spi_disable;

   // queue to register file
   logic        load_en;
   core_data_t  load_data;
   logic        core_pending;

   //##########################################################################
   // serial engine
   //##########################################################################

   spi_slave_io i_spi_slave_io (
      .clk         (clk),
      .nreset      (nreset),
      .sclk        (sclk),
      .ss_n        (ss_n),
      .mosi        (mosi),
      .miso        (miso),
      .spi_disable (spi_disable),
      .rd_en       (rd_en),
      .rd_addr     (rd_addr),
      .rd_data     (rd_data),
      .wr_en       (wr_en),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data)
   );

   // register map
   spi_slave_regs i_spi_slave_regs (
      .clk          (clk),
      .nreset       (nreset),
      .rd_en        (rd_en),
      .rd_addr      (rd_addr),
      .rd_data      (rd_data),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .spi_disable  (spi_disable),
      .load_en      (load_en),
      .load_data    (load_data),
      .core_pending (core_pending),
      .user_valid   (user_valid),
      .user_regs    (user_regs)
   );

   // core word buffer with credit return
   core_packet_queue i_core_packet_queue (
      .clk          (clk),
      .nreset       (nreset),
      .core_access  (core_access),
      .core_data    (core_data),
      .core_credit  (core_credit),
      .core_pending (core_pending),
      .load_en      (load_en),
      .load_data    (load_data)
   );

endmodule

// File: verif/spi_slave_checker.sv
`include "spi_regmap.svh"

module spi_slave_checker (
   input  logic                                       clk,
   input  logic                                       nreset,
   input  logic                                       sclk,
   input  logic                                       ss_n,
   input  logic                                       mosi,
   input  logic                                       miso,
   input  logic                                       core_access,
   input  spi_slave_pkg::core_data_t                  core_data,
   input  logic                                       core_credit,
   input  logic                                       user_valid,
   input  logic [spi_slave_pkg::NUM_USER_REGS*8-1:0]  user_regs,
   input  int                                         test_id,
   input  logic                                       test_done,
   output int                                         tests_passed,
   output int                                         tests_failed
);
   timeunit 1ns;
   timeprecision 1ps;
   import spi_slave_pkg::*;

   localparam int VEC_W = NUM_USER_REGS * 8;

   // register map model
   byte_t       cfg_model;
   logic        pending_model;
   core_data_t  word_model;
   byte_t       user_model [NUM_USER_REGS];
   core_data_t  queue_model [$];
   int          pushes;
   int          pops;
   int          credit_pulses;
   int          test_errors;

   // frame decoder
   int          bit_cnt;
   int          byte_idx;
   byte_t       mosi_byte;
   byte_t       miso_byte;
   byte_t       exp_byte;
   reg_addr_t   exp_addr;
   reg_addr_t   cur_addr;
   logic        is_read;

   initial
   begin
      cfg_model     = '0;
      pending_model = 1'b0;
      word_model    = '0;
      foreach (user_model[i])
         user_model[i] = '0;
      pushes        = 0;
      pops          = 0;
      credit_pulses = 0;
      test_errors   = 0;
      tests_passed  = 0;
      tests_failed  = 0;
      bit_cnt       = 0;
      byte_idx      = 0;
   end

   function automatic string test_label(input int id);
      case (id)
         1:       return "user_write_burst";
         2:       return "map_read_burst";
         3:       return "port_disable";
         4:       return "core_data_order";
         5:       return "credit_accounting";
         default: return "setup";
      endcase
   endfunction

   task automatic report_mismatch(input string what, input logic [VEC_W-1:0] exp,
                                  input logic [VEC_W-1:0] act);
      $display("ERR %s %s expected %0h actual %0h", test_label(test_id), what, exp, act);
      test_errors++;
   endtask

   task automatic plain_error(input string msg);
      $display("%s: %s", test_label(test_id), msg);
      test_errors++;
   endtask

   //##########################################################################
   // model behavior
   //##########################################################################

   // next queued word moves in once the window is free
   task automatic pop_model();
      if (queue_model.size() > 0 && !pending_model)
      begin
         word_model    = queue_model.pop_front();
         pending_model = 1'b1;
         pops++;
      end
   endtask

   // byte fetch where the top core byte releases the word
   task automatic fetch_next();
      exp_addr = cur_addr;
      if (cur_addr == `SPI_CONFIG)
         exp_byte = cfg_model;
      else if (cur_addr == `SPI_STATUS)
         exp_byte = {7'b0, pending_model};
      else if (cur_addr < CORE_BASE)
         exp_byte = '0;
      else if (cur_addr <= CORE_LAST)
         exp_byte = word_model[(int'(cur_addr) - CORE_BASE) * 8 +: 8];
      else
         exp_byte = user_model[int'(cur_addr) - USER_BASE];
      if (cur_addr == reg_addr_t'(CORE_LAST))
      begin
         pending_model = 1'b0;
         pop_model();
      end
      cur_addr = cur_addr + 1'b1;
   endtask

   task automatic model_write(input reg_addr_t a, input byte_t d);
      // port disable lets only config through
      if (cfg_model[`CFG_DISABLE] && a != `SPI_CONFIG)
         return;
      if (a == `SPI_CONFIG)
         cfg_model = d;
      else if (a >= USER_BASE)
         user_model[int'(a) - USER_BASE] = d;
   endtask

   task automatic check_outputs();
      logic [VEC_W-1:0] exp_vec;
      for (int i = 0; i < NUM_USER_REGS; i++)
         exp_vec[i*8 +: 8] = user_model[i];
      if (user_regs !== exp_vec)
         report_mismatch("user_regs", exp_vec, user_regs);
      if (user_valid !== cfg_model[`CFG_USER_VALID])
         report_mismatch("user_valid", cfg_model[`CFG_USER_VALID], user_valid);
   endtask

   // every pop returns exactly one credit
   task automatic check_credits(input string what);
      if (credit_pulses != pops)
         report_mismatch(what, pops, credit_pulses);
   endtask

   //##########################################################################
   // pin decoding
   //##########################################################################

   always @(negedge ss_n)
   begin
      bit_cnt  = 0;
      byte_idx = 0;
      check_credits("credits at frame start");
   end

   // all writes visible a few cycles after deselect
   always @(posedge ss_n)
   begin
      repeat (5) @(negedge clk);
      check_outputs();
      check_credits("credits at frame end");
   end

   // mode 0 samples both lines on the rising edge
   always @(posedge sclk)
   begin
      if (nreset && !ss_n)
      begin
         mosi_byte = {mosi_byte[6:0], mosi};
         miso_byte = {miso_byte[6:0], miso};
         bit_cnt++;
         if (bit_cnt == 8)
         begin
            bit_cnt = 0;
            if (byte_idx == 0)
            begin
               // command byte with bit 6 ignored
               is_read  = mosi_byte[7];
               cur_addr = mosi_byte[5:0];
               if (is_read)
                  fetch_next();
            end
            else if (is_read)
            begin
               if (miso_byte !== exp_byte)
                  report_mismatch($sformatf("miso addr %0d", exp_addr), exp_byte, miso_byte);
               // engine prefetches the next byte
               fetch_next();
            end
            else
            begin
               model_write(cur_addr, mosi_byte);
               cur_addr = cur_addr + 1'b1;
            end
            byte_idx++;
         end
      end
   end

   // core side and idle line
   always @(negedge clk)
   begin
      if (nreset)
      begin
         if (core_access)
         begin
            // agent credits are the ones actually returned on core_credit
            if (QUEUE_DEPTH - pushes + credit_pulses <= 0)
               plain_error("core word pushed with no credit left");
            pushes++;
            queue_model.push_back(core_data);
            pop_model();
         end
         if (core_credit)
            credit_pulses++;
         if (ss_n && miso !== 1'b0)
            plain_error("miso driven while slave deselected");
      end
   end

   // one line per finished test
   always @(posedge test_done)
   begin
      check_outputs();
      check_credits("credits at test end");
      if (test_errors == 0)
      begin
         tests_passed++;
         $display("test %s done, no errors", test_label(test_id));
      end
      else
      begin
         tests_failed++;
         $display("test %s done, %0d errors", test_label(test_id), test_errors);
      end
      test_errors = 0;
   end

endmodule

// File: verif/spi_slave_tb.sv
`include "spi_regmap.svh"

module spi_slave_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import spi_slave_pkg::*;

   // 400 ns sclk half period
   localparam int HALF_SCLK_CLKS = 4;
   localparam int WAIT_LIMIT     = 200;

   typedef byte_t byte_q_t [$];

   logic                          clk;
   logic                          nreset;
   logic                          sclk;
   logic                          ss_n;
   logic                          mosi;
   logic                          miso;
   logic                          core_access;
   core_data_t                    core_data;
   logic                          core_credit;
   logic                          user_valid;
   logic [NUM_USER_REGS*8-1:0]    user_regs;
   int                            test_id;
   logic                          test_done;
   int                            tests_passed;
   int                            tests_failed;
   int                            seed;
   int                            credits;
   int                            tb_errors;

   spi_slave i_spi_slave (
      .clk         (clk),
      .nreset      (nreset),
      .sclk        (sclk),
      .ss_n        (ss_n),
      .mosi        (mosi),
      .miso        (miso),
      .core_access (core_access),
      .core_data   (core_data),
      .core_credit (core_credit),
      .user_valid  (user_valid),
      .user_regs   (user_regs)
   );

   spi_slave_checker i_checker (
      .clk          (clk),
      .nreset       (nreset),
      .sclk         (sclk),
      .ss_n         (ss_n),
      .mosi         (mosi),
      .miso         (miso),
      .core_access  (core_access),
      .core_data    (core_data),
      .core_credit  (core_credit),
      .user_valid   (user_valid),
      .user_regs    (user_regs),
      .test_id      (test_id),
      .test_done    (test_done),
      .tests_passed (tests_passed),
      .tests_failed (tests_failed)
   );

   always #50 clk = ~clk;

   // agent side credit count
   always @(negedge clk)
   begin
      if (nreset && core_credit)
         credits++;
   end

   //##########################################################################
   // stimulus helpers
   //##########################################################################

   task automatic tick();
      @(posedge clk);
      #10;
   endtask

   task automatic half_sclk();
      repeat (HALF_SCLK_CLKS) tick();
   endtask

   function automatic int rand_range(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic byte_q_t random_bytes(input int n);
      byte_q_t q;
      for (int i = 0; i < n; i++)
         q.push_back(byte_t'($random(seed)));
      return q;
   endfunction

   // msb first, mosi changes with the falling edge
   task automatic send_byte(input byte_t b);
      for (int i = 7; i >= 0; i--)
      begin
         mosi = b[i];
         half_sclk();
         sclk = 1'b1;
         half_sclk();
         sclk = 1'b0;
      end
   endtask

   task automatic spi_frame(input byte_t cmd, input byte_q_t data);
      ss_n = 1'b0;
      half_sclk();
      send_byte(cmd);
      foreach (data[i])
         send_byte(data[i]);
      half_sclk();
      ss_n = 1'b1;
      repeat (8) tick();
   endtask

   // bit 6 of the command is random, it must not matter
   task automatic spi_write(input reg_addr_t start, input byte_q_t data);
      spi_frame({1'b0, rand_range(2) == 1, start}, data);
   endtask

   task automatic spi_read(input reg_addr_t start, input int len);
      spi_frame({1'b1, rand_range(2) == 1, start}, random_bytes(len));
   endtask

   task automatic write_one(input reg_addr_t a, input byte_t d);
      byte_q_t q;
      q.push_back(d);
      spi_write(a, q);
   endtask

   task automatic wait_for_credit();
      int n;
      n = 0;
      while (credits == 0 && n < WAIT_LIMIT)
      begin
         tick();
         n++;
      end
      if (credits == 0)
      begin
         $display("timeout: no core credit came back after %0d cycles", WAIT_LIMIT);
         tb_errors++;
      end
   endtask

   task automatic push_core_word();
      core_data_t w;
      w[31:0]  = $random(seed);
      w[63:32] = $random(seed);
      wait_for_credit();
      if (credits > 0)
      begin
         core_access = 1'b1;
         core_data   = w;
         credits--;
         tick();
         core_access = 1'b0;
         repeat (4) tick();
      end
   endtask

   task automatic end_test();
      repeat (4) tick();
      test_done = 1'b1;
      tick();
      test_done = 1'b0;
   endtask

   //##########################################################################
   // test sequence
   //##########################################################################

   initial
   begin
      reg_addr_t start;
      int        len;
      byte_q_t   data;
      clk         = 1'b0;
      nreset      = 1'b0;
      sclk        = 1'b0;
      ss_n        = 1'b1;
      mosi        = 1'b0;
      core_access = 1'b0;
      core_data   = '0;
      test_id     = 0;
      test_done   = 1'b0;
      seed        = 7570;
      credits     = QUEUE_DEPTH;
      tb_errors   = 0;
      repeat (16) @(posedge clk);
      #10;
      nreset = 1'b1;
      repeat (4) tick();

      // random user bursts, config byte kept at valid on wrap
      test_id = 1;
      for (int f = 0; f < 8; f++)
      begin
         start = reg_addr_t'(USER_BASE + rand_range(NUM_USER_REGS));
         len   = 1 + rand_range(60);
         data  = random_bytes(len);
         for (int i = 0; i < len; i++)
            if (reg_addr_t'(start + i) == `SPI_CONFIG)
               data[i] = 8'h01;
         spi_write(start, data);
      end
      end_test();

      // whole map reads with one word loaded
      test_id = 2;
      push_core_word();
      for (int f = 0; f < 8; f++)
         spi_read(reg_addr_t'(rand_range(64)), 1 + rand_range(64));
      end_test();

      // disable blocks user space but not config
      test_id = 3;
      write_one(`SPI_CONFIG, 8'h03);
      spi_write(reg_addr_t'(20), random_bytes(10));
      data    = random_bytes(3);
      data[2] = 8'h01;
      spi_write(reg_addr_t'(62), data);
      spi_write(reg_addr_t'(40), random_bytes(4));
      spi_read(`SPI_CONFIG, 2);
      write_one(`SPI_CONFIG, 8'h00);
      spi_read(`SPI_CONFIG, 1);
      end_test();

      // words come out in push order
      test_id = 4;
      spi_read(reg_addr_t'(CORE_BASE), 8);
      push_core_word();
      push_core_word();
      spi_read(`SPI_STATUS, 15);
      spi_read(`SPI_STATUS, 15);
      spi_read(`SPI_STATUS, 1);
      end_test();

      // spend every credit, only a read of the last core byte frees one
      test_id = 5;
      push_core_word();
      push_core_word();
      push_core_word();
      repeat (40) tick();
      spi_read(reg_addr_t'(CORE_LAST), 1);
      wait_for_credit();
      spi_read(reg_addr_t'(CORE_BASE), 8);
      spi_read(reg_addr_t'(CORE_BASE), 8);
      spi_read(`SPI_STATUS, 1);
      end_test();

      repeat (4) tick();
      $display("tests passed %0d failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && tb_errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// File: list.f
+incdir+include
verilog/spi_slave_pkg.sv
verilog/spi_slave_io.sv
verilog/spi_slave_regs.sv
verilog/core_packet_queue.sv
verilog/spi_slave.sv
verif/spi_slave_checker.sv
verif/spi_slave_tb.sv

// File: Bender.yml
package:
  name: spi_slave

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/spi_slave_pkg.sv
      - verilog/spi_slave_io.sv
      - verilog/spi_slave_regs.sv
      - verilog/core_packet_queue.sv
      - verilog/spi_slave.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/spi_slave_checker.sv
      - verif/spi_slave_tb.sv
